//--- source/vdp_defs.svh
`ifndef VDP_DEFS_SVH
`define VDP_DEFS_SVH

// VRAM geometry
`define VDP_VRAM_AW        14
`define VDP_NUM_REGS       8

// Raster in pixel clocks and lines
`define VDP_H_TOTAL        342
`define VDP_V_TOTAL        262
`define VDP_H_ACTIVE       256
`define VDP_V_ACTIVE       192

`define VDP_H_SYNC_START   279   // After right border and blanking
`define VDP_H_SYNC_LEN     26
`define VDP_V_SYNC_START   216
`define VDP_V_SYNC_LEN     3

// One byte per 8x8 cell, 32 cells per row
`define VDP_NAME_BASE      14'h0800

`endif

//--- source/vdp_pkg.sv
`include "vdp_defs.svh"

package vdp_pkg;

   typedef logic [7:0] vdp_byte_t;

   typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;

   typedef logic [$clog2(`VDP_NUM_REGS)-1:0] reg_idx_t;

   // CPU port sequencing
   typedef enum logic [1:0] {
      IDLE,          // Ready for any access
      CTRL_SECOND,   // First control byte held
      PREFETCH,      // Read-ahead pending in VRAM
      WRITE_PEND     // Data write pending in VRAM
   } cpu_state_t;

endpackage

//--- source/vdp_cpu_port.sv
module vdp_cpu_port (
   input  logic                clk,
   input  logic                rst_i,
   input  vdp_pkg::vdp_byte_t  cd_i,
   input  logic                csr_i,
   input  logic                csw_i,
   input  logic                mode_i,
   input  logic                cpu_done_i,
   input  vdp_pkg::vdp_byte_t  cpu_rdata_i,
   input  vdp_pkg::vdp_byte_t  status_rdata_i,
   output vdp_pkg::vdp_byte_t  cq_o,
   output logic                cpu_req_o,
   output logic                cpu_we_o,
   output vdp_pkg::vram_addr_t cpu_addr_o,
   output vdp_pkg::vdp_byte_t  cpu_wdata_o,
   output logic                reg_wstrobe_o,
   output vdp_pkg::reg_idx_t   reg_addr_o,
   output vdp_pkg::vdp_byte_t  reg_wdata_o,
   output logic                status_rstrobe_o
);

   vdp_pkg::cpu_state_t state;
   vdp_pkg::vram_addr_t addr;
   vdp_pkg::vdp_byte_t  ctrl_lo;    // First control byte
   vdp_pkg::vdp_byte_t  read_buf;   // Read-ahead byte
   logic                accept;
   logic                ctrl_wr;
   logic                data_wr;
   logic                ctrl_rd;
   logic                data_rd;

   // Strobes are dropped while a VRAM access is outstanding
   assign accept = (state == vdp_pkg::IDLE) || (state == vdp_pkg::CTRL_SECOND);

   assign ctrl_wr = accept && csw_i && mode_i;
   assign data_wr = accept && csw_i && !mode_i;
   assign ctrl_rd = accept && csr_i && mode_i;
   assign data_rd = accept && csr_i && !mode_i;

   assign cpu_req_o  = (state == vdp_pkg::PREFETCH) || (state == vdp_pkg::WRITE_PEND);
   assign cpu_we_o   = (state == vdp_pkg::WRITE_PEND);
   assign cpu_addr_o = addr;

   // Second byte with bit 7 set selects a register write
   assign reg_wstrobe_o    = ctrl_wr && (state == vdp_pkg::CTRL_SECOND) && cd_i[7];
   assign reg_addr_o       = cd_i[2:0];
   assign reg_wdata_o      = ctrl_lo;
   assign status_rstrobe_o = ctrl_rd;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= vdp_pkg::IDLE;
         addr  <= '0;
      end else begin
         case (state)
            vdp_pkg::IDLE,
            vdp_pkg::CTRL_SECOND: begin
               if (ctrl_wr) begin
                  if (state == vdp_pkg::IDLE) begin
                     state <= vdp_pkg::CTRL_SECOND;
                  end else if (cd_i[7]) begin
                     state <= vdp_pkg::IDLE;
                  end else begin
                     addr  <= {cd_i[5:0], ctrl_lo};
                     // Bit 6 clear is a read setup, fill the buffer
                     state <= cd_i[6] ? vdp_pkg::IDLE : vdp_pkg::PREFETCH;
                  end
               end else if (data_wr) begin
                  state <= vdp_pkg::WRITE_PEND;
               end else if (data_rd) begin
                  addr  <= addr + 1'b1;
                  state <= vdp_pkg::PREFETCH;
               end else if (ctrl_rd) begin
                  state <= vdp_pkg::IDLE;   // Resets byte toggle
               end
            end
            vdp_pkg::PREFETCH: begin
               if (cpu_done_i) begin
                  state <= vdp_pkg::IDLE;
               end
            end
            vdp_pkg::WRITE_PEND: begin
               if (cpu_done_i) begin
                  addr  <= addr + 1'b1;
                  state <= vdp_pkg::IDLE;
               end
            end
            default: state <= vdp_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_wr && (state == vdp_pkg::IDLE)) begin
         ctrl_lo <= cd_i;
      end
      if (data_wr) begin
         cpu_wdata_o <= cd_i;
      end
      if ((state == vdp_pkg::PREFETCH) && cpu_done_i) begin
         read_buf <= cpu_rdata_i;
      end
      if (data_rd) begin
         cq_o <= read_buf;
      end else if (ctrl_rd) begin
         cq_o <= status_rdata_i;   // Sampled before the flag clears
      end
   end

endmodule

//--- source/vdp_video_timer.sv
`include "vdp_defs.svh"

module vdp_video_timer (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                clk_en_i,
   output logic                sync_h_o,
   output logic                sync_v_o,
   output logic                active_o,
   output logic                fetch_o,
   output vdp_pkg::vram_addr_t fetch_addr_o,
   output logic                fetch_valid_o,
   output logic                frame_start_o
);

   localparam logic [8:0] H_LAST   = 9'(`VDP_H_TOTAL - 1);
   localparam logic [8:0] V_LAST   = 9'(`VDP_V_TOTAL - 1);
   localparam logic [8:0] H_ACT    = 9'(`VDP_H_ACTIVE);
   localparam logic [8:0] V_ACT    = 9'(`VDP_V_ACTIVE);
   localparam logic [8:0] HS_START = 9'(`VDP_H_SYNC_START);
   localparam logic [8:0] HS_END   = 9'(`VDP_H_SYNC_START + `VDP_H_SYNC_LEN);
   localparam logic [8:0] VS_START = 9'(`VDP_V_SYNC_START);
   localparam logic [8:0] VS_END   = 9'(`VDP_V_SYNC_START + `VDP_V_SYNC_LEN);

   logic [8:0] h_cnt;
   logic [8:0] v_cnt;
   logic       in_active;

   assign in_active = (h_cnt < H_ACT) && (v_cnt < V_ACT);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (clk_en_i) begin
         if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? 9'd0 : v_cnt + 9'd1;
         end else begin
            h_cnt <= h_cnt + 9'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         sync_h_o      <= 1'b0;
         sync_v_o      <= 1'b0;
         active_o      <= 1'b0;
         fetch_valid_o <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         sync_h_o      <= (h_cnt >= HS_START) && (h_cnt < HS_END);
         sync_v_o      <= (v_cnt >= VS_START) && (v_cnt < VS_END);
         active_o      <= in_active;
         fetch_valid_o <= fetch_o;   // VRAM data lands now
         // Counter moves to pixel 0 of the first border line
         frame_start_o <= clk_en_i && (h_cnt == H_LAST) && (v_cnt == V_ACT - 9'd1);
      end
   end

   // One name byte per 8-pixel cell
   assign fetch_o      = clk_en_i && in_active && (h_cnt[2:0] == 3'd0);
   assign fetch_addr_o = `VDP_NAME_BASE + {4'd0, v_cnt[7:3], h_cnt[7:3]};

endmodule

//--- source/vdp_regs.sv
`include "vdp_defs.svh"

module vdp_regs (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               reg_wstrobe_i,
   input  vdp_pkg::reg_idx_t  reg_addr_i,
   input  vdp_pkg::vdp_byte_t reg_wdata_i,
   input  logic               status_rstrobe_i,
   input  logic               frame_start_i,
   output vdp_pkg::vdp_byte_t status_rdata_o,
   output logic [3:0]         backdrop_o,
   output logic               int_pending_o
);

   vdp_pkg::vdp_byte_t ctrl_regs [`VDP_NUM_REGS];
   logic               frame_flag;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < `VDP_NUM_REGS; i++) begin
            ctrl_regs[i] <= '0;
         end
      end else if (reg_wstrobe_i) begin
         ctrl_regs[reg_addr_i] <= reg_wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         frame_flag <= 1'b0;
      end else if (frame_start_i) begin
         frame_flag <= 1'b1;   // New frame beats a status read
      end else if (status_rstrobe_i) begin
         frame_flag <= 1'b0;
      end
   end

   assign status_rdata_o = {frame_flag, 7'd0};
   assign backdrop_o     = ctrl_regs[7][3:0];

   // Reg 1 bit 5 is the frame interrupt enable
   assign int_pending_o = frame_flag && ctrl_regs[1][5];

endmodule

//--- source/vdp_vram.sv
`include "vdp_defs.svh"

module vdp_vram (
   input  logic                clk,
   input  logic                fetch_i,
   input  vdp_pkg::vram_addr_t fetch_addr_i,
   input  logic                cpu_req_i,
   input  logic                cpu_we_i,
   input  vdp_pkg::vram_addr_t cpu_addr_i,
   input  vdp_pkg::vdp_byte_t  cpu_wdata_i,
   output vdp_pkg::vdp_byte_t  vid_data_o,
   output logic                cpu_done_o,
   output vdp_pkg::vdp_byte_t  cpu_rdata_o
);

   localparam int DEPTH = 1 << `VDP_VRAM_AW;

   vdp_pkg::vdp_byte_t mem [DEPTH];
   logic               cpu_slot;

   // Request still high during its done cycle, skip it then
   assign cpu_slot = !fetch_i && cpu_req_i && !cpu_done_o;

   always_ff @(posedge clk) begin
      if (fetch_i) begin
         vid_data_o <= mem[fetch_addr_i];   // Video owns the cycle
      end else if (cpu_slot) begin
         if (cpu_we_i) begin
            mem[cpu_addr_i] <= cpu_wdata_i;
         end else begin
            cpu_rdata_o <= mem[cpu_addr_i];
         end
      end
   end

   always_ff @(posedge clk) begin
      cpu_done_o <= cpu_slot;
   end

endmodule

//--- source/vdp_top.sv
module vdp_top (
   input  logic               clk,
   input  logic               clk_en_i,   // One pixel per enable
   input  logic               rst_i,
   input  vdp_pkg::vdp_byte_t cd_i,
   input  logic               csr_i,
   input  logic               csw_i,
   input  logic               mode_i,
   output vdp_pkg::vdp_byte_t cq_o,
   output logic               int_pending_o,
   output logic               sync_h_o,
   output logic               sync_v_o,
   output logic [3:0]         color_o
);

   logic                cpu_req;
   logic                cpu_we;
   vdp_pkg::vram_addr_t cpu_addr;
   vdp_pkg::vdp_byte_t  cpu_wdata;
   logic                cpu_done;
   vdp_pkg::vdp_byte_t  cpu_rdata;

   logic                reg_wstrobe;
   vdp_pkg::reg_idx_t   reg_addr;
   vdp_pkg::vdp_byte_t  reg_wdata;
   logic                status_rstrobe;
   vdp_pkg::vdp_byte_t  status_rdata;
   logic [3:0]          backdrop;

   logic                active;
   logic                fetch;
   vdp_pkg::vram_addr_t fetch_addr;
   logic                fetch_valid;
   vdp_pkg::vdp_byte_t  vid_data;
   logic                frame_start;

   vdp_cpu_port i_cpu_port (
      .clk(clk), .rst_i(rst_i),
      .cd_i(cd_i), .csr_i(csr_i), .csw_i(csw_i), .mode_i(mode_i),
      .cpu_done_i(cpu_done), .cpu_rdata_i(cpu_rdata), .status_rdata_i(status_rdata),
      .cq_o(cq_o), .cpu_req_o(cpu_req), .cpu_we_o(cpu_we),
      .cpu_addr_o(cpu_addr), .cpu_wdata_o(cpu_wdata),
      .reg_wstrobe_o(reg_wstrobe), .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata),
      .status_rstrobe_o(status_rstrobe));

   vdp_video_timer i_video_timer (
      .clk(clk), .rst_i(rst_i), .clk_en_i(clk_en_i),
      .sync_h_o(sync_h_o), .sync_v_o(sync_v_o), .active_o(active),
      .fetch_o(fetch), .fetch_addr_o(fetch_addr), .fetch_valid_o(fetch_valid),
      .frame_start_o(frame_start));

   vdp_regs i_regs (
      .clk(clk), .rst_i(rst_i),
      .reg_wstrobe_i(reg_wstrobe), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
      .status_rstrobe_i(status_rstrobe), .frame_start_i(frame_start),
      .status_rdata_o(status_rdata), .backdrop_o(backdrop),
      .int_pending_o(int_pending_o));

   vdp_vram i_vram (
      .clk(clk),
      .fetch_i(fetch), .fetch_addr_i(fetch_addr),
      .cpu_req_i(cpu_req), .cpu_we_i(cpu_we),
      .cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
      .vid_data_o(vid_data), .cpu_done_o(cpu_done), .cpu_rdata_o(cpu_rdata));

   // Colour 0 in the name byte shows the backdrop
   always_ff @(posedge clk) begin
      if (rst_i) begin
         color_o <= 4'd0;
      end else if (fetch_valid) begin
         color_o <= (vid_data[3:0] != 4'd0) ? vid_data[3:0] : backdrop;
      end else if (!active) begin
         color_o <= 4'd0;   // Border and blanking
      end
   end

endmodule

//--- testbench/vdp_properties.sv
`include "vdp_defs.svh"

module vdp_properties (
   input logic                clk, rst_i, clk_en_i,
   input vdp_pkg::vdp_byte_t  cd_i, cq_i,
   input logic                csr_i, csw_i, mode_i,
   input logic                int_pending_i, sync_h_i, sync_v_i,
   input logic [3:0]          color_i,
   input logic                cpu_req_i, cpu_done_i, frame_start_i,
   input vdp_pkg::cpu_state_t state_i,
   input logic [8:0]          h_cnt_i, v_cnt_i
);

   vdp_pkg::vdp_byte_t  shadow [16];   // Last byte per low address nibble
   logic [15:0]         shadow_vld;
   vdp_pkg::vdp_byte_t  ctrl_lo, rd_exp;
   vdp_pkg::vram_addr_t addr;
   logic                toggle, irq_en, name0_zero, rd_chk, h_seen;
   logic [3:0]          backdrop;
   int                  h_ticks, v_ticks;
   int                  fail_cnt = 0;

   task automatic report_failure(input string what);
      fail_cnt++;
      $error("FAIL %0t: %s", $time, what);
   endtask

   // Reference model of the CPU port, driven by the pin-level strobes
   always_ff @(posedge clk) begin
      if (rst_i) begin
         toggle     <= 1'b0;
         shadow_vld <= '0;
         irq_en     <= 1'b0;
         backdrop   <= 4'd0;
         name0_zero <= 1'b0;
         rd_chk     <= 1'b0;
      end else begin
         rd_chk <= csr_i && !mode_i && shadow_vld[addr[3:0]];
         rd_exp <= shadow[addr[3:0]];
         if (csw_i && mode_i) begin
            toggle <= !toggle;
            if (!toggle) begin
               ctrl_lo <= cd_i;
            end else if (!cd_i[7]) begin
               addr <= {cd_i[5:0], ctrl_lo};
            end else if (cd_i[2:0] == 3'd1) begin
               irq_en <= ctrl_lo[5];
            end else if (cd_i[2:0] == 3'd7) begin
               backdrop <= ctrl_lo[3:0];
            end
         end else if (csr_i || csw_i) begin
            toggle <= 1'b0;   // Any other access restarts the pair
            if (!mode_i) begin
               addr <= addr + 1'b1;
            end
            if (csw_i) begin
               shadow[addr[3:0]]     <= cd_i;
               shadow_vld[addr[3:0]] <= 1'b1;
               if (addr == `VDP_NAME_BASE) begin
                  name0_zero <= (cd_i[3:0] == 4'd0);
               end
            end
         end
      end
   end

   // Pixel ticks since the last hsync rise, and inside vsync
   always_ff @(posedge clk) begin
      if (rst_i) begin
         h_ticks <= 0;
         v_ticks <= 0;
         h_seen  <= 1'b0;
      end else begin
         h_ticks <= $rose(sync_h_i) ? int'(clk_en_i) : h_ticks + int'(clk_en_i);
         v_ticks <= sync_v_i ? v_ticks + int'(clk_en_i) : 0;
         h_seen  <= h_seen || $rose(sync_h_i);
      end
   end

   a_reset_quiet: assert property (@(posedge clk) rst_i |=> !int_pending_i && !sync_h_i
      && !sync_v_i && !cpu_req_i && color_i == 4'd0) else report_failure("output active in reset");
   a_readback: assert property (@(posedge clk) disable iff (rst_i)
      rd_chk |-> cq_i == rd_exp) else report_failure("data read differs from byte written");
   a_status_clear: assert property (@(posedge clk) disable iff (rst_i)
      csr_i && mode_i && int_pending_i && !frame_start_i |=> cq_i[7] && !int_pending_i)
      else report_failure("status read did not report or clear the frame flag");
   a_irq_gate: assert property (@(posedge clk) disable iff (rst_i)
      !irq_en |-> !int_pending_i) else report_failure("interrupt raised while disabled");
   a_hsync_len: assert property (@(posedge clk) disable iff (rst_i)
      $fell(sync_h_i) |-> h_ticks == `VDP_H_SYNC_LEN) else report_failure("hsync width");
   a_hsync_period: assert property (@(posedge clk) disable iff (rst_i)
      $rose(sync_h_i) && h_seen |-> h_ticks == `VDP_H_TOTAL) else report_failure("hsync period");
   a_vsync_len: assert property (@(posedge clk) disable iff (rst_i)
      $fell(sync_v_i) |-> v_ticks == `VDP_V_SYNC_LEN * `VDP_H_TOTAL)
      else report_failure("vsync width");
   a_color_border: assert property (@(posedge clk) disable iff (rst_i)
      !(h_cnt_i < `VDP_H_ACTIVE && v_cnt_i < `VDP_V_ACTIVE) |-> ##2 color_i == 4'd0)
      else report_failure("colour outside the active area");
   a_color_backdrop: assert property (@(posedge clk) disable iff (rst_i)
      v_cnt_i == 9'd0 && h_cnt_i < 9'd8 && name0_zero |-> ##3 color_i == backdrop)
      else report_failure("transparent cell did not show the backdrop");
   a_req_done: assert property (@(posedge clk) disable iff (rst_i)
      $rose(cpu_req_i) |-> ##[1:16] cpu_done_i) else report_failure("VRAM access never done");
   a_no_overlap: assert property (@(posedge clk) disable iff (rst_i)
      state_i == vdp_pkg::PREFETCH || state_i == vdp_pkg::WRITE_PEND |-> !csr_i && !csw_i)
      else report_failure("CPU strobe during a pending VRAM access");

endmodule

bind vdp_top vdp_properties i_vdp_properties (
   .clk(clk), .rst_i(rst_i), .clk_en_i(clk_en_i), .cd_i(cd_i), .cq_i(cq_o),
   .csr_i(csr_i), .csw_i(csw_i), .mode_i(mode_i), .int_pending_i(int_pending_o),
   .sync_h_i(sync_h_o), .sync_v_i(sync_v_o), .color_i(color_o),
   .cpu_req_i(cpu_req), .cpu_done_i(cpu_done), .frame_start_i(frame_start),
   .state_i(i_cpu_port.state), .h_cnt_i(i_video_timer.h_cnt),
   .v_cnt_i(i_video_timer.v_cnt));

//--- testbench/vdp_tb.sv
`include "vdp_defs.svh"

module vdp_tb;

   logic                clk, clk_en_i, rst_i;
   logic                csr_i, csw_i, mode_i;
   vdp_pkg::vdp_byte_t  cd_i, cq_o;
   logic                int_pending_o, sync_h_o, sync_v_o;
   logic [3:0]          color_o;
   vdp_pkg::vram_addr_t base;
   integer              seed;
   int                  timeouts;

   vdp_top i_vdp_top (
      .clk(clk), .clk_en_i(clk_en_i), .rst_i(rst_i), .cd_i(cd_i),
      .csr_i(csr_i), .csw_i(csw_i), .mode_i(mode_i), .cq_o(cq_o),
      .int_pending_o(int_pending_o), .sync_h_o(sync_h_o), .sync_v_o(sync_v_o),
      .color_o(color_o));

   always #20 clk = !clk;

   always @(posedge clk) begin
      clk_en_i <= !clk_en_i;   // One pixel every second clock
   end

   // One strobe cycle, then the gap the VRAM arbiter needs
   task automatic cpu_access(input logic write, input logic ctrl, input vdp_pkg::vdp_byte_t data);
      @(posedge clk);
      cd_i   <= data;
      mode_i <= ctrl;
      csw_i  <= write;
      csr_i  <= !write;
      @(posedge clk);
      csw_i <= 1'b0;
      csr_i <= 1'b0;
      repeat (7) @(posedge clk);
   endtask

   task automatic write_reg(input logic [2:0] idx, input vdp_pkg::vdp_byte_t value);
      cpu_access(1'b1, 1'b1, value);
      cpu_access(1'b1, 1'b1, {5'b10000, idx});
   endtask

   task automatic set_address(input vdp_pkg::vram_addr_t addr, input logic write);
      cpu_access(1'b1, 1'b1, addr[7:0]);
      cpu_access(1'b1, 1'b1, {1'b0, write, addr[13:8]});
   endtask

   // Interrupt line when irq is set, else vsync; a frame is 179208 clocks
   task automatic wait_level(input logic irq, input logic level, input string what);
      int n;
      n = 0;
      @(negedge clk);   // Outputs settled mid-cycle
      while ((irq ? int_pending_o : sync_v_o) !== level && n < 200000) begin
         @(negedge clk);
         n++;
      end
      if ((irq ? int_pending_o : sync_v_o) !== level) begin
         timeouts++;
         $display("Timeout while waiting for %s", what);
      end
   endtask

   initial begin
      clk      = 1'b0;
      clk_en_i = 1'b0;
      rst_i    = 1'b1;
      cd_i     = '0;
      csr_i    = 1'b0;
      csw_i    = 1'b0;
      mode_i   = 1'b0;
      seed     = 32'h61da;
      timeouts = 0;
      repeat (10) @(posedge clk);
      rst_i <= 1'b0;

      base = 14'($random(seed));
      set_address(base, 1'b1);
      repeat (8) cpu_access(1'b1, 1'b0, 8'($random(seed)));
      set_address(base, 1'b0);   // Read-ahead of the first byte
      repeat (8) cpu_access(1'b0, 1'b0, 8'h00);

      write_reg(3'd1, 8'h20);
      repeat (2) begin
         wait_level(1'b1, 1'b1, "the frame interrupt");
         cpu_access(1'b0, 1'b1, 8'h00);
      end
      write_reg(3'd1, 8'h00);
      wait_level(1'b0, 1'b1, "vsync to start");
      wait_level(1'b0, 1'b0, "vsync to end");
      wait_level(1'b0, 1'b1, "vsync to start");

      // Colour 0 in name entry 0 shows the backdrop on line 0
      write_reg(3'd7, {4'h0, 4'($random(seed)) | 4'h1});
      set_address(`VDP_NAME_BASE, 1'b1);
      cpu_access(1'b1, 1'b0, 8'h00);
      wait_level(1'b0, 1'b0, "vsync to end");
      wait_level(1'b0, 1'b1, "vsync to start");

      $display("Errors: %0d assertion failures, %0d timeouts",
               i_vdp_top.i_vdp_properties.fail_cnt, timeouts);
      if (i_vdp_top.i_vdp_properties.fail_cnt == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+source
source/vdp_pkg.sv
source/vdp_cpu_port.sv
source/vdp_video_timer.sv
source/vdp_regs.sv
source/vdp_vram.sv
source/vdp_top.sv
testbench/vdp_properties.sv
testbench/vdp_tb.sv
